// File: flash_model.sv
`timescale 1ns/1ps

module flash_model (
  input  logic                               CLK_50M,
  input  logic                               reset,
  input  logic                               flash_read,
  input  logic [flash_pkg::FLASH_ADDR_W-1:0] flash_address,
  output logic                               flash_waitrequest,
  output logic                               flash_readdatavalid,
  output logic [flash_pkg::FLASH_DATA_W-1:0] flash_readdata
);

  integer                             seed = 32'hbece_15ab;
  logic [31:0]                        rnd;
  logic                               busy;
  logic [1:0]                         pend_wait;  // Wait states for the next read
  logic [2:0]                         lat_left;
  logic [flash_pkg::FLASH_ADDR_W-1:0] addr_q;

  // Byte b of word a is (4a+b) ^ 0x5A, upper address bits folded in
  function automatic logic [31:0] word_at(input logic [flash_pkg::FLASH_ADDR_W-1:0] a);
    logic [7:0]  fold;
    logic [31:0] w;
    int          b;
    fold = 8'(a >> 6) ^ 8'(a >> 14) ^ 8'(a >> 22);
    for (b = 0; b < flash_pkg::BYTES_PER_WORD; b++)
      w[b*8 +: 8] = 8'(4 * a + b) ^ 8'h5A ^ fold;
    return w;
  endfunction

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      flash_waitrequest   <= 1'b0;
      flash_readdatavalid <= 1'b0;
      flash_readdata      <= '0;
      busy                <= 1'b0;
      pend_wait           <= '0;
      lat_left            <= '0;
      addr_q              <= '0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (busy)
      begin
        if (lat_left == 3'd1)
        begin
          flash_readdata      <= word_at(addr_q);
          flash_readdatavalid <= 1'b1;
          busy                <= 1'b0;
          flash_waitrequest   <= (pend_wait != 0);
        end
        else
          lat_left <= lat_left - 1'b1;
      end
      else if (flash_read)
      begin
        if (!flash_waitrequest)  // Read taken this cycle
        begin
          rnd = $random(seed);
          busy              <= 1'b1;
          addr_q            <= flash_address;
          lat_left          <= 3'd1 + rnd[1:0];
          pend_wait         <= rnd[3:2];
          flash_waitrequest <= 1'b1;
        end
        else if (pend_wait <= 2'd1)
        begin
          pend_wait         <= '0;
          flash_waitrequest <= 1'b0;
        end
        else
          pend_wait <= pend_wait - 1'b1;
      end
    end
  end

endmodule

// File: flash_pkg.sv
package flash_pkg;

  // ========================================
  // Flash bus geometry
  // ========================================
  localparam int FLASH_ADDR_W = 23;  // Word address
  localparam int FLASH_DATA_W = 32;

  // Four 8-bit samples per word, low byte first
  localparam int BYTES_PER_WORD = 4;

  // ========================================
  // Song layout
  // ========================================
  // Last word of the song as stored in flash
  localparam logic [FLASH_ADDR_W-1:0] SONG_LAST_ADDR = 23'h7FFFF;

endpackage

// File: flash_sample_reader.sv
`timescale 1ns/1ps

module flash_sample_reader #(
  parameter logic [flash_pkg::FLASH_ADDR_W-1:0] last_word_addr = flash_pkg::SONG_LAST_ADDR
) (
  input  logic                                CLK_50M,
  input  logic                                reset,
  input  logic                                sample_tick,
  input  logic                                play_enable,
  input  logic                                direction,
  input  logic                                restart_req,
  input  logic                                flash_waitrequest,
  input  logic                                flash_readdatavalid,
  input  logic [flash_pkg::FLASH_DATA_W-1:0]  flash_readdata,
  output logic                                flash_read,
  output logic [flash_pkg::FLASH_ADDR_W-1:0]  flash_address,
  output logic [player_pkg::SAMPLE_W-1:0]     audio_out,
  output logic                                audio_valid
);

  localparam int BYTE_IDX_W = $clog2(flash_pkg::BYTES_PER_WORD);
  localparam logic [BYTE_IDX_W-1:0] LAST_BYTE = BYTE_IDX_W'(flash_pkg::BYTES_PER_WORD - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data,
    st_emit
  } reader_state_t;

  reader_state_t                     state;
  logic [flash_pkg::FLASH_ADDR_W-1:0] word_addr;
  logic [BYTE_IDX_W-1:0]             byte_idx;
  logic [flash_pkg::FLASH_DATA_W-1:0] cache_word;
  logic                              cache_valid;
  logic                              drop_data;  // Restart hit an open fetch

  logic [flash_pkg::FLASH_ADDR_W-1:0] next_addr;
  logic [BYTE_IDX_W-1:0]             next_byte;
  logic                              word_done;
  logic [player_pkg::SAMPLE_W-1:0]   cur_byte;

  assign cur_byte = cache_word[byte_idx * player_pkg::SAMPLE_W +: player_pkg::SAMPLE_W];

  // ========================================
  // Position sequencer
  // ========================================
  always_comb
  begin
    next_addr = word_addr;
    next_byte = byte_idx;
    word_done = 1'b0;
    if (!direction)
    begin
      if (byte_idx == LAST_BYTE)
      begin
        word_done = 1'b1;
        next_byte = '0;
        next_addr = (word_addr == last_word_addr) ? '0 : word_addr + 1'b1;  // Wrap to start
      end
      else
        next_byte = byte_idx + 1'b1;
    end
    else
    begin
      if (byte_idx == '0)
      begin
        word_done = 1'b1;
        next_byte = LAST_BYTE;
        next_addr = (word_addr == '0) ? last_word_addr : word_addr - 1'b1;  // Wrap to end
      end
      else
        next_byte = byte_idx - 1'b1;
    end
  end

  // ========================================
  // Read FSM
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state         <= st_idle;
      word_addr     <= '0;
      byte_idx      <= '0;
      cache_valid   <= 1'b0;
      drop_data     <= 1'b0;
      flash_read    <= 1'b0;
      flash_address <= '0;
      audio_out     <= '0;
      audio_valid   <= 1'b0;
    end
    else
    begin
      audio_valid <= 1'b0;
      case (state)
        st_idle:
          if (restart_req)
            ;  // Position handled below, tick dropped
          else if (sample_tick && play_enable)
          begin
            if (cache_valid)
            begin
              audio_out   <= cur_byte;  // Cached byte goes out next cycle
              audio_valid <= 1'b1;
              word_addr   <= next_addr;
              byte_idx    <= next_byte;
              if (word_done)
                cache_valid <= 1'b0;
            end
            else
            begin
              flash_address <= word_addr;
              flash_read    <= 1'b1;
              state         <= st_request;
            end
          end
        st_request:
          if (!flash_waitrequest)  // Accepted this cycle
          begin
            flash_read <= 1'b0;
            state      <= st_wait_data;
          end
        st_wait_data:
          if (flash_readdatavalid)
          begin
            if (drop_data || restart_req)
              state <= st_idle;
            else
            begin
              cache_word  <= flash_readdata;
              cache_valid <= 1'b1;
              state       <= st_emit;
            end
            drop_data <= 1'b0;
          end
        st_emit:
        begin
          if (!restart_req)
          begin
            audio_out   <= cur_byte;
            audio_valid <= 1'b1;
            word_addr   <= next_addr;
            byte_idx    <= next_byte;
            if (word_done)
              cache_valid <= 1'b0;
          end
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase

      // Restart overrides position and cache in every state
      if (restart_req)
      begin
        cache_valid <= 1'b0;
        word_addr   <= direction ? last_word_addr : '0;
        byte_idx    <= direction ? LAST_BYTE : '0;
        if (state == st_request || (state == st_wait_data && !flash_readdatavalid))
          drop_data <= 1'b1;  // Let the bus finish, throw the word away
      end
    end
  end

endmodule

// File: ipod_player.f
player_pkg.sv
flash_pkg.sv
kbd_command_decoder.sv
sample_rate_gen.sv
flash_sample_reader.sv
ipod_player_top.sv
flash_model.sv
ipod_player_asserts.sv
tb_ipod_player.sv

// File: ipod_player_asserts.sv
`timescale 1ns/1ps

module ipod_player_asserts (
  input logic                               CLK_50M,
  input logic                               reset,
  input logic                               flash_read,
  input logic [flash_pkg::FLASH_ADDR_W-1:0] flash_address,
  input logic                               flash_waitrequest,
  input logic                               audio_valid,
  input logic                               play_enable
);

  // Request held until the flash takes it
  hold_request: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("flash_read or flash_address changed while waitrequest was high");

  single_strobe: assert property (@(posedge CLK_50M) disable iff (reset)
    audio_valid |=> !audio_valid)
    else $error("audio_valid lasted two cycles");

  // A fetch starts only from a tick taken while playing
  read_when_playing: assert property (@(posedge CLK_50M) disable iff (reset)
    $rose(flash_read) |-> $past(play_enable))
    else $error("flash read started while playback was stopped");

endmodule

// File: ipod_player_top.sv
`timescale 1ns/1ps

module ipod_player_top #(
  parameter logic [flash_pkg::FLASH_ADDR_W-1:0] last_word_addr = flash_pkg::SONG_LAST_ADDR
) (
  input  logic                               CLK_50M,
  input  logic                               reset,
  // Keyboard and speed buttons
  input  logic                               kbd_valid,
  input  logic [7:0]                         kbd_ascii,
  input  logic                               speed_up,
  input  logic                               speed_down,
  input  logic                               speed_reset,
  // Flash bus
  input  logic                               flash_waitrequest,
  input  logic                               flash_readdatavalid,
  input  logic [flash_pkg::FLASH_DATA_W-1:0] flash_readdata,
  output logic                               flash_read,
  output logic [flash_pkg::FLASH_ADDR_W-1:0] flash_address,
  // Audio and status
  output logic [player_pkg::SAMPLE_W-1:0]    audio_out,
  output logic                               audio_valid,
  output logic [player_pkg::PERIOD_W-1:0]    sample_period,
  output logic                               play_enable,
  output logic                               direction
);

  logic restart_req;
  logic sample_tick;

  // ========================================
  // Control path
  // ========================================
  kbd_command_decoder i_kbd_command_decoder (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .kbd_valid   (kbd_valid),
    .kbd_ascii   (kbd_ascii),
    .play_enable (play_enable),
    .direction   (direction),
    .restart_req (restart_req)
  );

  sample_rate_gen i_sample_rate_gen (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .sample_tick   (sample_tick),
    .sample_period (sample_period)  // Also shown to the outside
  );

  // ========================================
  // Flash to audio
  // ========================================
  flash_sample_reader #(
    .last_word_addr (last_word_addr)
  ) i_flash_sample_reader (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .sample_tick         (sample_tick),
    .play_enable         (play_enable),
    .direction           (direction),
    .restart_req         (restart_req),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_out           (audio_out),
    .audio_valid         (audio_valid)
  );

endmodule

// File: kbd_command_decoder.sv
`timescale 1ns/1ps

module kbd_command_decoder (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       kbd_valid,
  input  logic [7:0] kbd_ascii,
  output logic       play_enable,
  output logic       direction,   // 1 = backward
  output logic       restart_req
);

  logic [7:0]            ascii_upper;
  player_pkg::kbd_cmd_t  cmd;

  assign ascii_upper = kbd_ascii & player_pkg::ASCII_CASE_MASK;  // Fold case

  // Letter to opcode
  always_comb
  begin
    case (ascii_upper)
      player_pkg::ASCII_PLAY:    cmd = player_pkg::cmd_play;
      player_pkg::ASCII_STOP:    cmd = player_pkg::cmd_stop;
      player_pkg::ASCII_FWD:     cmd = player_pkg::cmd_forward;
      player_pkg::ASCII_BWD:     cmd = player_pkg::cmd_backward;
      player_pkg::ASCII_RESTART: cmd = player_pkg::cmd_restart;
      default:                   cmd = player_pkg::cmd_none;
    endcase
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      play_enable <= 1'b0;
      direction   <= 1'b0;
      restart_req <= 1'b0;
    end
    else
    begin
      restart_req <= 1'b0;  // Single-cycle pulse
      if (kbd_valid)
      begin
        case (cmd)
          player_pkg::cmd_play:     play_enable <= 1'b1;
          player_pkg::cmd_stop:     play_enable <= 1'b0;
          player_pkg::cmd_forward:  direction   <= 1'b0;
          player_pkg::cmd_backward: direction   <= 1'b1;
          player_pkg::cmd_restart:  restart_req <= 1'b1;
          default:                  ;  // Unknown key, no change
        endcase
      end
    end
  end

endmodule

// File: player_pkg.sv
package player_pkg;

  // ========================================
  // Keyboard commands
  // ========================================
  typedef enum logic [2:0] {
    cmd_none,
    cmd_play,
    cmd_stop,
    cmd_forward,
    cmd_backward,
    cmd_restart
  } kbd_cmd_t;

  localparam logic [7:0] ASCII_PLAY      = 8'h45;  // 'E'
  localparam logic [7:0] ASCII_STOP      = 8'h44;  // 'D'
  localparam logic [7:0] ASCII_FWD       = 8'h46;  // 'F'
  localparam logic [7:0] ASCII_BWD       = 8'h42;  // 'B'
  localparam logic [7:0] ASCII_RESTART   = 8'h52;  // 'R'
  localparam logic [7:0] ASCII_CASE_MASK = 8'hDF;  // Clears bit 5, lower to upper

  // ========================================
  // Sample stream and period
  // ========================================
  localparam int SAMPLE_W = 8;
  localparam int PERIOD_W = 16;

  localparam logic [PERIOD_W-1:0] PERIOD_DEFAULT = 16'd1136;  // About 44 kHz at 50 MHz
  localparam logic [PERIOD_W-1:0] PERIOD_STEP    = 16'd64;
  localparam logic [PERIOD_W-1:0] PERIOD_MIN     = 16'd256;
  localparam logic [PERIOD_W-1:0] PERIOD_MAX     = 16'd4096;

endpackage

// File: sample_rate_gen.sv
`timescale 1ns/1ps

module sample_rate_gen (
  input  logic                            CLK_50M,
  input  logic                            reset,
  input  logic                            speed_up,
  input  logic                            speed_down,
  input  logic                            speed_reset,
  output logic                            sample_tick,
  output logic [player_pkg::PERIOD_W-1:0] sample_period
);

  logic [player_pkg::PERIOD_W-1:0] tick_count;

  // ========================================
  // Period register
  // ========================================
  // Priority is reset event, then up, then down
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sample_period <= player_pkg::PERIOD_DEFAULT;
    else if (speed_reset)
      sample_period <= player_pkg::PERIOD_DEFAULT;
    else if (speed_up)
    begin
      if (sample_period <= player_pkg::PERIOD_MIN + player_pkg::PERIOD_STEP)
        sample_period <= player_pkg::PERIOD_MIN;  // Fastest rate
      else
        sample_period <= sample_period - player_pkg::PERIOD_STEP;
    end
    else if (speed_down)
    begin
      if (sample_period >= player_pkg::PERIOD_MAX - player_pkg::PERIOD_STEP)
        sample_period <= player_pkg::PERIOD_MAX;  // Slowest rate
      else
        sample_period <= sample_period + player_pkg::PERIOD_STEP;
    end
  end

  // ========================================
  // Tick counter
  // ========================================
  // Wraps every sample_period cycles; the >= compare also catches a
  // period that just shrank below the running count
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_count >= sample_period - 1'b1)
    begin
      tick_count  <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_count  <= tick_count + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

// File: tb_ipod_player.sv
`timescale 1ns/1ps

module tb_ipod_player;

  localparam int          CLK_PERIOD = 20;
  localparam logic [22:0] LAST_ADDR  = 23'd3;
  // Samples per test with stop windows counted as samples
  localparam int TOTAL_SAMPLES   = 22 + 11 + 26 + 12 + 24;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * int'(player_pkg::PERIOD_MAX) * 2;

  logic        CLK_50M = 1'b0;
  logic        reset;
  logic        kbd_valid;
  logic [7:0]  kbd_ascii;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_waitrequest;
  logic        flash_readdatavalid;
  logic [31:0] flash_readdata;
  logic        flash_read;
  logic [22:0] flash_address;
  logic [7:0]  audio_out;
  logic        audio_valid;
  logic [15:0] sample_period;
  logic        play_enable;
  logic        direction;

  // Position model and bookkeeping
  logic [22:0] exp_addr;
  logic [1:0]  exp_byte;
  logic        tb_dir;
  logic        quiet;  // Set while no audio may appear
  logic [15:0] exp_period;
  logic        prev_cached = 1'b0;
  logic        gap_cached  = 1'b0;
  int          error_count  = 0;
  int          check_count  = 0;
  int          failed_tests = 0;
  int          sample_count = 0;
  int          cycle_no     = 0;
  int          last_cycle   = 0;
  int          last_gap     = 0;

  always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

  ipod_player_top #(.last_word_addr(LAST_ADDR)) i_dut (.*);
  flash_model i_flash (.*);

  bind flash_sample_reader ipod_player_asserts i_asserts (
    .CLK_50M           (CLK_50M),
    .reset             (reset),
    .flash_read        (flash_read),
    .flash_address     (flash_address),
    .flash_waitrequest (flash_waitrequest),
    .audio_valid       (audio_valid),
    .play_enable       (play_enable)
  );

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [7:0] expected_sample(input logic [22:0] addr, input logic [1:0] idx);
    logic [7:0] fold;
    fold = 8'(addr >> 6) ^ 8'(addr >> 14) ^ 8'(addr >> 22);  // Zero for short songs
    return 8'(4 * addr + idx) ^ 8'h5A ^ fold;
  endfunction

  task advance_position;
    if (!tb_dir)
    begin
      if (exp_byte == 2'd3)
        exp_addr = (exp_addr == LAST_ADDR) ? '0 : exp_addr + 1'b1;
      exp_byte = exp_byte + 1'b1;  // Two-bit index wraps by itself
    end
    else
    begin
      if (exp_byte == 2'd0)
        exp_addr = (exp_addr == '0) ? LAST_ADDR : exp_addr - 1'b1;
      exp_byte = exp_byte - 1'b1;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      error_count++;
    end
  endtask

  // ========================================
  // Output comparison
  // ========================================
  always @(posedge CLK_50M)
    cycle_no <= cycle_no + 1;

  always @(negedge CLK_50M)
  begin
    logic this_cached;
    if (!reset && audio_valid)
    begin
      if (quiet)
      begin
        $display("Error: audio_valid appeared while playback should be stopped");
        error_count++;
      end
      else
      begin
        check_value("audio_out", audio_out, expected_sample(exp_addr, exp_byte));
        this_cached = tb_dir ? (exp_byte != 2'd3) : (exp_byte != 2'd0);  // Not a word start
        gap_cached  = prev_cached && this_cached;
        prev_cached = this_cached;
        last_gap    = cycle_no - last_cycle;
        last_cycle  = cycle_no;
        advance_position();
        sample_count++;
      end
    end
  end

  // ========================================
  // Stimulus helpers
  // ========================================
  task wait_samples(input int n);
    int target;
    target = sample_count + n;
    wait (sample_count >= target);
  endtask

  task send_key(input logic [7:0] ascii);
    @(posedge CLK_50M);
    kbd_valid <= 1'b1;
    kbd_ascii <= ascii;
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
    @(negedge CLK_50M);
  endtask

  task speed_event(input logic up, input logic down, input logic rst);
    int period_next;
    @(posedge CLK_50M);
    speed_up    <= up;
    speed_down  <= down;
    speed_reset <= rst;
    @(posedge CLK_50M);
    speed_up    <= 1'b0;
    speed_down  <= 1'b0;
    speed_reset <= 1'b0;
    period_next = exp_period;
    if (rst)
      period_next = player_pkg::PERIOD_DEFAULT;
    else if (up)
      period_next = period_next - int'(player_pkg::PERIOD_STEP);
    else if (down)
      period_next = period_next + int'(player_pkg::PERIOD_STEP);
    if (period_next < int'(player_pkg::PERIOD_MIN))
      period_next = player_pkg::PERIOD_MIN;
    if (period_next > int'(player_pkg::PERIOD_MAX))
      period_next = player_pkg::PERIOD_MAX;
    exp_period = period_next;
    @(negedge CLK_50M);
    check_value("sample_period", sample_period, exp_period);
  endtask

  // Spacing of two cached bytes once the new period is running
  task check_gap;
    wait_samples(2);
    wait_samples(1);
    while (!gap_cached)
      wait_samples(1);
    check_value("audio_valid spacing", last_gap, exp_period);
  endtask

  task report_test(input string name, input int errors_before);
    if (error_count == errors_before)
      $display("Test %s: passed", name);
    else
    begin
      $display("Test %s: failed with %0d errors", name, error_count - errors_before);
      failed_tests++;
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial
  begin
    int errs;
    reset       = 1'b1;
    kbd_valid   = 1'b0;
    kbd_ascii   = 8'h00;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_addr    = '0;
    exp_byte    = '0;
    tb_dir      = 1'b0;
    quiet       = 1'b1;
    exp_period  = player_pkg::PERIOD_DEFAULT;
    repeat (4) @(posedge CLK_50M);
    reset <= 1'b0;

    errs = error_count;
    repeat (2 * player_pkg::PERIOD_DEFAULT) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_value("sample_period", sample_period, player_pkg::PERIOD_DEFAULT);
    quiet = 1'b0;
    send_key("E");
    wait_samples(20);  // Crosses the wrap from word 3 to word 0
    report_test("1 reset and start", errs);

    errs = error_count;
    quiet = 1'b1;
    send_key("d");
    check_value("play_enable", play_enable, 1'b0);
    repeat (3 * exp_period) @(posedge CLK_50M);
    quiet = 1'b0;
    send_key("E");
    wait_samples(8);
    report_test("2 stop and resume", errs);

    errs = error_count;
    tb_dir = 1'b1;
    send_key("B");
    wait_samples(20);  // Goes below address 0
    tb_dir = 1'b0;
    send_key("F");
    wait_samples(6);  // Ends in the middle of word 3
    report_test("3 backward order", errs);

    errs = error_count;
    send_key("R");
    exp_addr = '0;
    exp_byte = 2'd0;
    wait_samples(4);
    tb_dir = 1'b1;
    send_key("B");
    send_key("r");
    exp_addr = LAST_ADDR;
    exp_byte = 2'd3;
    wait_samples(4);
    send_key("x");
    send_key("Q");
    send_key("1");
    check_value("play_enable", play_enable, 1'b1);
    check_value("direction", direction, tb_dir);
    wait_samples(4);
    tb_dir = 1'b0;
    send_key("F");
    report_test("4 restart", errs);

    errs = error_count;
    repeat (3) speed_event(1'b1, 1'b0, 1'b0);
    check_gap();
    repeat (14) speed_event(1'b1, 1'b0, 1'b0);  // Runs into PERIOD_MIN
    check_gap();
    speed_event(1'b1, 1'b1, 1'b0);
    speed_event(1'b0, 1'b0, 1'b1);
    repeat (48) speed_event(1'b0, 1'b1, 1'b0);  // Runs into PERIOD_MAX
    check_gap();
    speed_event(1'b1, 1'b1, 1'b1);
    check_gap();
    report_test("5 speed control", errs);

    $display("Tests run: 5, failed: %0d, checks: %0d, errors: %0d",
             failed_tests, check_count, error_count);
    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
